// File: hw/spi_msg_config.svh
`ifndef SPI_MSG_CONFIG_SVH
`define SPI_MSG_CONFIG_SVH

// ==============================
// Message framing
// ==============================

// Whole message, type byte on top of the argument
`define MSG_LEN        64
`define MSG_TYPE_LEN   8
`define MSG_ARG_LEN    56

// Response is a full 64-bit word
`define RESP_LEN       64

// ==============================
// Lanes and pacing
// ==============================

// Host sends on d[3:0]; we answer on two such lanes
`define LANE_WIDTH     4

// Nibbles per message on the four input lines
`define MSG_NIBBLES    16

// Dummy byte in front of every message, host garbles its first nibble
`define DUMMY_NIBBLES  2

// LED port on the board
`define LED_WIDTH      4

`endif

// File: hw/spi_msg_pkg.sv
`include "spi_msg_config.svh"

package spi_msg_pkg;

    // ==============================
    // Message types
    // ==============================

    // Type byte sits in the top byte of the message
    // Anything not listed here is treated as a nop
    typedef enum logic [`MSG_TYPE_LEN-1:0] {
        MSG_NOP     = 8'h00,
        MSG_ECHO    = 8'h01,
        MSG_LED_SET = 8'h02
    } msg_type_t;

    // ==============================
    // Payload types
    // ==============================

    // Argument below the type byte
    // Echo returns all of it, LED set only looks at the low nibble
    typedef logic [`MSG_ARG_LEN-1:0] msg_arg_t;

    // Response word
    // Sent back byte by byte, most significant byte first
    typedef logic [`RESP_LEN-1:0] resp_t;

endpackage

// File: hw/spi_msg_if.sv
`include "spi_msg_config.svh"

interface spi_msg_if import spi_msg_pkg::*; ();

    // Decoded message, single-cycle strobe, no back-pressure
    logic      msg_valid;
    msg_type_t msg_type;
    msg_arg_t  msg_arg;

    // Response word, also a single-cycle strobe
    logic      resp_valid;
    resp_t     resp_data;

    // Receiver drives the message fields
    modport rx (
        output msg_valid,
        output msg_type,
        output msg_arg
    );

    // Dispatcher consumes the message and produces the response
    modport dispatch (
        input  msg_valid,
        input  msg_type,
        input  msg_arg,
        output resp_valid,
        output resp_data
    );

    // Transmitter only sees the response
    modport tx (
        input  resp_valid,
        input  resp_data
    );

endinterface

// File: hw/spi_msg_rx.sv
`include "spi_msg_config.svh"

module spi_msg_rx import spi_msg_pkg::*; (
    input  logic                   ice_st_spi_clk,
    input  logic                   spi_cs,
    input  logic [`LANE_WIDTH-1:0] spi_d_in,
    spi_msg_if.rx                  msg
);

    // Dummy nibbles plus message nibbles, counted down to zero
    localparam int NIBBLE_TOTAL = `DUMMY_NIBBLES + `MSG_NIBBLES;
    localparam int CNT_WIDTH    = $clog2(NIBBLE_TOTAL);

    // Start value and the count of the first message nibble
    localparam logic [CNT_WIDTH-1:0] CNT_START    = CNT_WIDTH'(NIBBLE_TOTAL - 1);
    localparam logic [CNT_WIDTH-1:0] CNT_MSG_LAST = CNT_WIDTH'(`MSG_NIBBLES - 1);

    logic [CNT_WIDTH-1:0] cnt_q;
    logic                 done_q;
    logic                 valid_q;
    logic [`MSG_LEN-1:0]  shift_q;

    // ==============================
    // Nibble counter
    // ==============================

    // Deselect restarts the count for the next message
    // Count 0 is the last message nibble, strobe goes out right after it
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            cnt_q   <= CNT_START;
            done_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!done_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    done_q  <= 1'b1;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // ==============================
    // Message shift register
    // ==============================

    // Dummy counts are skipped, then MSB nibble first
    always_ff @(posedge ice_st_spi_clk) begin
        if (!done_q && (cnt_q <= CNT_MSG_LAST)) begin
            shift_q <= {shift_q[`MSG_LEN-`LANE_WIDTH-1:0], spi_d_in};
        end
    end

    // Fields held stable once done, only sampled on the strobe anyway
    assign msg.msg_valid = valid_q;
    assign msg.msg_type  = msg_type_t'(shift_q[`MSG_LEN-1 -: `MSG_TYPE_LEN]);
    assign msg.msg_arg   = shift_q[`MSG_ARG_LEN-1:0];

    // Host must be driving the lines on every edge we still sample
    a_din_known: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        !done_q |-> !$isunknown(spi_d_in)
    );

    // One message per selection, so the strobe never lingers
    a_valid_pulse: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        msg.msg_valid |=> !msg.msg_valid
    );

endmodule

// File: hw/spi_cmd_dispatch.sv
`include "spi_msg_config.svh"

module spi_cmd_dispatch import spi_msg_pkg::*; (
    input  logic                  ice_st_spi_clk,
    input  logic                  spi_cs,
    spi_msg_if.dispatch           msg,
    output logic [`LED_WIDTH-1:0] ice_led
);

    // LED state survives deselection, zero only at power-up
    logic [`LED_WIDTH-1:0] led_q = '0;

    logic  is_echo;
    logic  is_led_set;
    logic  resp_valid_q;
    resp_t resp_next;
    resp_t resp_data_q;

    // ==============================
    // Type decode
    // ==============================

    always_comb begin
        is_echo    = 1'b0;
        is_led_set = 1'b0;
        case (msg.msg_type)
            MSG_ECHO: begin
                is_echo = 1'b1;
            end
            MSG_LED_SET: begin
                is_led_set = 1'b1;
            end
            // No response, output stays off for this selection
            MSG_NOP: begin
            end
            // Unknown types fall back to nop
            default: begin
            end
        endcase
    end

    // Echo returns the argument, LED set returns the value it replaces
    always_comb begin
        if (is_led_set) begin
            resp_next = {{(`RESP_LEN-`LED_WIDTH){1'b0}}, led_q};
        end else begin
            resp_next = {{(`RESP_LEN-`MSG_ARG_LEN){1'b0}}, msg.msg_arg};
        end
    end

    // ==============================
    // Response and LED registers
    // ==============================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= msg.msg_valid && (is_echo || is_led_set);
        end
    end

    // Response word captured alongside the strobe
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg.msg_valid && (is_echo || is_led_set)) begin
            resp_data_q <= resp_next;
        end
    end

    // Old value already sits in resp_next when the new one lands
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg.msg_valid && is_led_set) begin
            led_q <= msg.msg_arg[`LED_WIDTH-1:0];
        end
    end

    assign msg.resp_valid = resp_valid_q;
    assign msg.resp_data  = resp_data_q;
    assign ice_led        = led_q;

    // A response only ever answers the message strobe one cycle back
    a_resp_follows_msg: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        msg.resp_valid |-> $past(msg.msg_valid)
    );

endmodule

// File: hw/spi_resp_tx.sv
`include "spi_msg_config.svh"

module spi_resp_tx import spi_msg_pkg::*; (
    input  logic                     ice_st_spi_clk,
    input  logic                     spi_cs,
    spi_msg_if.tx                    resp,
    output logic [2*`LANE_WIDTH-1:0] spi_d_out,
    output logic                     spi_d_out_en
);

    // Two bytes per pair of cycles, eight cycles for the whole word
    localparam int RESP_CYCLES = `RESP_LEN / (2*`LANE_WIDTH);
    localparam int CNT_WIDTH   = $clog2(RESP_CYCLES);

    // Top nibble of the earlier byte and of the later byte in the pair
    localparam int TOP_B0 = `RESP_LEN - 1;
    localparam int TOP_B1 = `RESP_LEN - 9;

    logic                 en_q;
    logic                 run_q;
    logic                 load;
    logic [CNT_WIDTH-1:0] cnt_q;
    resp_t                shift_q;

    // Only the first response of a selection is taken
    assign load = resp.resp_valid && !en_q;

    // ==============================
    // Output control
    // ==============================

    // Enable stays up after the word is out, until deselect
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            en_q  <= 1'b0;
            run_q <= 1'b0;
            cnt_q <= '0;
        end else if (load) begin
            en_q  <= 1'b1;
            run_q <= 1'b1;
            cnt_q <= CNT_WIDTH'(RESP_CYCLES - 1);
        end else if (run_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == '0) begin
                run_q <= 1'b0;
            end
        end
    end

    // Odd count shows upper nibbles, step 4 to reach the lower ones
    // Even count shows lower nibbles, step 12 more to the next byte pair
    always_ff @(posedge ice_st_spi_clk) begin
        if (load) begin
            shift_q <= resp.resp_data;
        end else if (run_q) begin
            shift_q <= cnt_q[0] ? (shift_q << `LANE_WIDTH) : (shift_q << (3*`LANE_WIDTH));
        end
    end

    // Earlier byte on lane 3:0, later byte on lane 7:4
    assign spi_d_out    = run_q ? {shift_q[TOP_B1 -: `LANE_WIDTH],
                                   shift_q[TOP_B0 -: `LANE_WIDTH]} : '0;
    assign spi_d_out_en = en_q;

    // Lines are quiet whenever the pads are not driving
    a_quiet_when_off: assert property (
        @(posedge ice_st_spi_clk) disable iff (!spi_cs)
        !spi_d_out_en |-> (spi_d_out == '0)
    );

endmodule

// File: hw/spi_msg_top.sv
`include "spi_msg_config.svh"

module spi_msg_top (
    input  logic                     ice_st_spi_clk,
    input  logic                     spi_cs,
    input  logic [2*`LANE_WIDTH-1:0] spi_d_in,
    output logic [2*`LANE_WIDTH-1:0] spi_d_out,
    output logic                     spi_d_out_en,
    output logic [`LED_WIDTH-1:0]    ice_led
);

    // ==============================
    // Message path
    // ==============================

    spi_msg_if i_msg_if ();

    // Commands only use the low four lines
    spi_msg_rx i_rx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in[`LANE_WIDTH-1:0]),
        .msg            (i_msg_if.rx)
    );

    spi_cmd_dispatch i_dispatch (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg            (i_msg_if.dispatch),
        .ice_led        (ice_led)
    );

    // Pads and tri-state live in the board wrapper
    spi_resp_tx i_tx (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp           (i_msg_if.tx),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en)
    );

endmodule

// File: sim/spi_msg_tb.sv
`include "spi_msg_config.svh"

module spi_msg_tb import spi_msg_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                  ice_st_spi_clk;
    logic                  spi_cs;
    logic [7:0]            spi_d_in;
    logic [7:0]            spi_d_out;
    logic                  spi_d_out_en;
    logic [`LED_WIDTH-1:0] ice_led;

    // Galois LFSR state for argument bits
    logic [15:0]           lfsr_q = 16'd41597;
    logic [`LED_WIDTH-1:0] led_model = '0;
    int                    errs;
    int                    pass_cnt = 0;
    int                    fail_cnt = 0;

    spi_msg_top i_dut (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .spi_d_in       (spi_d_in),
        .spi_d_out      (spi_d_out),
        .spi_d_out_en   (spi_d_out_en),
        .ice_led        (ice_led)
    );

    // 4 ns clock
    initial begin
        ice_st_spi_clk = 1'b0;
        forever #2 ice_st_spi_clk = ~ice_st_spi_clk;
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    // One step per bit taken, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic msg_arg_t rand_arg();
        msg_arg_t a;
        int       i;
        a = '0;
        for (i = 0; i < `MSG_ARG_LEN; i++) begin
            a = {a[`MSG_ARG_LEN-2:0], next_bit()};
        end
        return a;
    endfunction

    // Deselect for 2 cycles, dummy byte of ones, then n_msg nibbles MSB first
    // Returns just before the edge that samples the last nibble driven
    task automatic send_msg(input logic [`MSG_TYPE_LEN-1:0] t, input msg_arg_t a,
                            input int n_msg);
        logic [`MSG_LEN-1:0] word;
        int                  i;
        word = {t, a};
        @(negedge ice_st_spi_clk);
        spi_cs   = 1'b0;
        spi_d_in = '0;
        repeat (2) @(negedge ice_st_spi_clk);
        spi_cs   = 1'b1;
        spi_d_in = 8'h0F;
        @(negedge ice_st_spi_clk);
        spi_d_in = 8'h0F;
        for (i = 0; i < n_msg; i++) begin
            @(negedge ice_st_spi_clk);
            spi_d_in = {4'h0, word[`MSG_LEN-1-4*i -: 4]};
        end
    endtask

    // Wait for the enable, then rebuild the word from 8 lane pairs
    task automatic recv_resp(input string name, output resp_t r, output int lat);
        int c;
        int b0;
        int sh;
        r   = '0;
        lat = 0;
        do begin
            @(negedge ice_st_spi_clk);
            lat++;
        end while (!spi_d_out_en && lat < 40);
        if (!spi_d_out_en) begin
            $display("%s: timed out waiting for spi_d_out_en", name);
            errs++;
            return;
        end
        for (c = 0; c < 8; c++) begin
            if (c > 0) begin
                @(negedge ice_st_spi_clk);
            end
            // Upper nibbles first in each pair, earlier byte on lane 3:0
            b0 = 2 * (c / 2);
            sh = (c % 2 == 0) ? 0 : 4;
            r[`RESP_LEN-1-8*b0-sh -: 4] = spi_d_out[3:0];
            r[`RESP_LEN-9-8*b0-sh -: 4] = spi_d_out[7:4];
        end
    endtask

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_led(input string name, input logic [`LED_WIDTH-1:0] exp,
                             input logic [`LED_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected led %h actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERROR %s: expected %0d cycles actual %0d", name, exp, act);
            errs++;
        end
    endtask

    // Enable must stay low for n cycles
    task automatic check_quiet(input string name, input int n);
        repeat (n) begin
            @(negedge ice_st_spi_clk);
            if (spi_d_out_en !== 1'b0) begin
                $display("ERROR %s: expected enable 0 actual %b", name, spi_d_out_en);
                errs++;
            end
        end
    endtask

    // Lanes zero with enable held after the word is out
    task automatic check_idle(input string name, input int n);
        repeat (n) begin
            @(negedge ice_st_spi_clk);
            if (spi_d_out_en !== 1'b1 || spi_d_out !== 8'h00) begin
                $display("ERROR %s: expected en 1 out 00 actual en %b out %h",
                         name, spi_d_out_en, spi_d_out);
                errs++;
            end
        end
    endtask

    task automatic report_test(input string name);
        if (errs == 0) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d mismatches", name, errs);
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic echo_basic();
        msg_arg_t a;
        resp_t    r;
        int       lat;
        errs = 0;
        a    = rand_arg();
        send_msg(MSG_ECHO, a, `MSG_NIBBLES);
        recv_resp("echo_basic", r, lat);
        // Edges 18, 19 and 20 pass before the enable is seen
        check_count("echo_basic", 3, lat);
        check_resp("echo_basic", {8'h00, a}, r);
        report_test("echo_basic");
    endtask

    // Response holds the LED value before the write
    task automatic led_set(input string name);
        msg_arg_t a;
        resp_t    r;
        int       lat;
        errs = 0;
        a    = rand_arg();
        send_msg(MSG_LED_SET, a, `MSG_NIBBLES);
        // Still the old value after a deselect
        check_led(name, led_model, ice_led);
        recv_resp(name, r, lat);
        check_resp(name, {{(`RESP_LEN-`LED_WIDTH){1'b0}}, led_model}, r);
        led_model = a[`LED_WIDTH-1:0];
        check_led(name, led_model, ice_led);
        report_test(name);
    endtask

    task automatic no_response();
        errs = 0;
        send_msg(MSG_NOP, rand_arg(), `MSG_NIBBLES);
        check_quiet("no_response", 12);
        send_msg(8'h7E, rand_arg(), `MSG_NIBBLES);
        check_quiet("no_response", 12);
        check_led("no_response", led_model, ice_led);
        report_test("no_response");
    endtask

    task automatic abort_mid_message();
        msg_arg_t a;
        resp_t    r;
        int       lat;
        errs = 0;
        // Six nibbles only, then the next send deselects
        send_msg(MSG_ECHO, rand_arg(), 6);
        check_quiet("abort_mid_message", 2);
        a = rand_arg();
        send_msg(MSG_ECHO, a, `MSG_NIBBLES);
        recv_resp("abort_mid_message", r, lat);
        // Leftover count from the cut message would raise the enable early
        check_count("abort_mid_message", 3, lat);
        check_resp("abort_mid_message", {8'h00, a}, r);
        report_test("abort_mid_message");
    endtask

    task automatic lanes_after_resp();
        msg_arg_t a;
        resp_t    r;
        int       lat;
        errs = 0;
        a    = rand_arg();
        send_msg(MSG_ECHO, a, `MSG_NIBBLES);
        recv_resp("lanes_after_resp", r, lat);
        check_resp("lanes_after_resp", {8'h00, a}, r);
        check_idle("lanes_after_resp", 6);
        report_test("lanes_after_resp");
    endtask

    initial begin
        spi_cs   = 1'b0;
        spi_d_in = '0;
        echo_basic();
        led_set("led_first_set");
        led_set("led_persist");
        no_response();
        abort_mid_message();
        lanes_after_resp();
        @(negedge ice_st_spi_clk);
        spi_cs = 1'b0;
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: spi_msg_top.f
+incdir+hw
hw/spi_msg_pkg.sv
hw/spi_msg_if.sv
hw/spi_msg_rx.sv
hw/spi_cmd_dispatch.sv
hw/spi_resp_tx.sv
hw/spi_msg_top.sv
sim/spi_msg_tb.sv
